// ==== digit_classifier.f ====
+incdir+logic
+incdir+verif
logic/num_pkg.sv
logic/link_pkg.sv
logic/design_ifs.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/scratch_ram.sv
logic/dense_accumulator.sv
logic/answer_select.sv
logic/infer_sequencer.sv
logic/digit_classifier.sv
verif/tb_digit_classifier.sv

// ==== verif/host_model.svh ====
`ifndef HOST_MODEL_SVH
`define HOST_MODEL_SVH

// one frame from the DUT, sampled near mid-bit on falling clock edges
task automatic receive_frame(output byte_t data);
    @(negedge tx);
    repeat (`CLS_CLKS_PER_BIT / 2) @(negedge clk);
    if (tx !== 1'b0) begin
        stop_on_fault("serial error: the start bit from the DUT did not stay low");
    end
    for (int i = 0; i < 8; i++) begin
        repeat (`CLS_CLKS_PER_BIT) @(negedge clk);
        data[i] = tx;
    end
    repeat (`CLS_CLKS_PER_BIT) @(negedge clk);
    if (tx !== 1'b1) begin
        stop_on_fault("serial error: the stop bit from the DUT was low");
    end
endtask

// 8N1 frame on rx after a random idle gap
task automatic send_frame(input byte_t data);
    int gap;
    gap = random_bits(3);
    repeat (gap + 1) @(negedge clk);
    rx = 1'b0;
    repeat (`CLS_CLKS_PER_BIT) @(negedge clk);
    for (int i = 0; i < 8; i++) begin
        rx = data[i];
        repeat (`CLS_CLKS_PER_BIT) @(negedge clk);
    end
    rx = 1'b1;
    repeat (`CLS_CLKS_PER_BIT) @(negedge clk);
endtask

task automatic next_tx_byte(output byte_t data);
    wait (tx_queue.size() != 0);
    data = tx_queue.pop_front();
endtask

// command byte, then file index high byte first
task automatic expect_header(input int cmd, input int file);
    byte_t b;
    next_tx_byte(b);
    check_value(b, cmd, "command byte");
    next_tx_byte(b);
    check_value(b, file >> 8, "file index high byte");
    next_tx_byte(b);
    check_value(b, file & 255, "file index low byte");
endtask

task automatic send_file(input int first, input int count);
    for (int i = 0; i < count; i++) begin
        send_frame(host_mem[first + i]);
    end
endtask

`endif

// ==== verif/tb_digit_classifier.sv ====
`timescale 1ns/1ps
`include "classifier_consts.svh"

module tb_digit_classifier;
    import link_pkg::*;

    localparam int W_BASE = `CLS_N_IN;
    localparam int B_BASE = `CLS_N_IN * (1 + `CLS_N_OUT);
    localparam int HOST_BYTES = B_BASE + `CLS_N_OUT;
    localparam int N_CASES = 5;
    localparam int WATCHDOG_CYCLES = N_CASES * (229 * 10 * `CLS_CLKS_PER_BIT + 400) * 2;

    // pattern kinds
    localparam int KIND_RANDOM = 0;
    localparam int KIND_ZERO = 1;
    localparam int KIND_EXTREME = 2;
    localparam int KIND_BIAS = 3;
    localparam int KIND_TIE = 4;

    // expected answer of -1 means the model alone decides
    int case_kind [N_CASES] = '{KIND_RANDOM, KIND_ZERO, KIND_EXTREME, KIND_BIAS, KIND_TIE};
    int case_answer [N_CASES] = '{-1, 0, 6, 8, 3};

    logic clk = 1'b0;
    logic reset = 1'b1;
    logic rx = 1'b1;
    logic tx;
    logic [4:0] state_led;
    num_pkg::row_t answer;
    logic number_valid;

    logic [15:0] lfsr_state = 16'd63;
    byte_t tx_queue [$];
    // inputs, then weights row-major, then biases
    logic signed [7:0] host_mem [HOST_BYTES];
    int model_score [`CLS_N_OUT];
    int model_answer;

    digit_classifier dut0 (
        .clk(clk),
        .reset(reset),
        .rx(rx),
        .tx(tx),
        .state_led(state_led),
        .answer(answer),
        .number_valid(number_valid)
    );

    always #50 clk = ~clk;

    function automatic logic lfsr_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ 16'hB400;
        end
        return out;
    endfunction

    function automatic int random_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | lfsr_bit();
        end
        return v;
    endfunction

    task automatic stop_on_fault(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
                               input string what);
        if (got !== expected) begin
            $display("ERROR at %0t ns: %s, got %0d, expected %0d", $time, what, got, expected);
            $display("Verification failed");
            $fatal(1, "mismatch");
        end
    endtask

    `include "host_model.svh"

    task automatic build_case(input int kind);
        for (int i = 0; i < HOST_BYTES; i++) begin
            host_mem[i] = (kind == KIND_ZERO) ? 0 : random_bits(8);
        end
        if (kind == KIND_EXTREME) begin
            for (int c = 0; c < `CLS_N_IN; c++) begin
                host_mem[c] = 8'sh80;
            end
        end
        for (int r = 0; r < `CLS_N_OUT; r++) begin
            for (int c = 0; c < `CLS_N_IN; c++) begin
                case (kind)
                    KIND_EXTREME: host_mem[W_BASE + r * 16 + c] =
                        (r == 6 || c % 2 == 1) ? 8'sh80 : 8'sh7f;
                    KIND_BIAS: host_mem[W_BASE + r * 16 + c] = 8'sh00;
                    // rows 3 and 7 square the inputs
                    KIND_TIE: host_mem[W_BASE + r * 16 + c] =
                        (r == 3 || r == 7) ? host_mem[c] : 8'sh00;
                    default: ;
                endcase
            end
            case (kind)
                KIND_EXTREME: host_mem[B_BASE + r] = (r % 2 == 0) ? 8'sh7f : 8'sh80;
                KIND_BIAS: host_mem[B_BASE + r] = (r == 8) ? 8'sh05 : 8'shff;
                KIND_TIE: host_mem[B_BASE + r] = (r == 3 || r == 7) ? 8'sh01 : 8'sh00;
                default: ;
            endcase
        end
    endtask

    // bias plus dot product per row and argmax with ties to the lowest row
    task automatic compute_model();
        for (int r = 0; r < `CLS_N_OUT; r++) begin
            model_score[r] = int'(host_mem[B_BASE + r]);
            for (int c = 0; c < `CLS_N_IN; c++) begin
                model_score[r] += int'(host_mem[c]) * int'(host_mem[W_BASE + r * 16 + c]);
            end
        end
        model_answer = 0;
        for (int r = 1; r < `CLS_N_OUT; r++) begin
            if (model_score[r] > model_score[model_answer]) begin
                model_answer = r;
            end
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        reset = 1'b1;
        rx = 1'b1;
        tx_queue.delete();
        repeat (2) @(negedge clk);
        check_value(tx, 1, "tx idle in reset");
        check_value(number_valid, 0, "number_valid in reset");
        check_value(state_led, 0, "state_led in reset");
        check_value(answer, 0, "answer in reset");
        reset = 1'b0;
    endtask

    // collects every frame the DUT sends
    initial begin
        byte_t b;
        forever begin
            receive_frame(b);
            tx_queue.push_back(b);
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: the DUT did not finish all table rows in time");
        $display("Verification failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        byte_t b;
        for (int k = 0; k < N_CASES; k++) begin
            build_case(case_kind[k]);
            compute_model();
            apply_reset();
            expect_header(`CLS_CMD_READ, 0);
            send_file(0, `CLS_N_IN);
            expect_header(`CLS_CMD_READ, 1);
            send_file(W_BASE, `CLS_N_IN * `CLS_N_OUT);
            expect_header(`CLS_CMD_READ, 2);
            send_file(B_BASE, `CLS_N_OUT);
            expect_header(`CLS_CMD_WRITE, 3);
            check_value(number_valid, 0, "number_valid before the score file");
            for (int r = 0; r < `CLS_N_OUT; r++) begin
                for (int j = 0; j < `CLS_SCORE_BYTES; j++) begin
                    next_tx_byte(b);
                    check_value(b, (model_score[r] >> (16 - 8 * j)) & 255,
                                $sformatf("case %0d score %0d byte %0d", k, r, j));
                end
            end
            wait (number_valid === 1'b1);
            @(negedge clk);
            check_value(answer, model_answer, $sformatf("case %0d answer", k));
            if (case_answer[k] >= 0) begin
                check_value(answer, case_answer[k], $sformatf("case %0d table answer", k));
            end
            // stray host bytes once finished
            send_frame(random_bits(8));
            send_frame(random_bits(8));
            repeat (20 * `CLS_CLKS_PER_BIT) @(negedge clk);
            check_value(number_valid, 1, "number_valid held");
            check_value(answer, model_answer, "answer held");
            check_value(state_led, FIN, "state_led in final phase");
            check_value(tx_queue.size(), 0, "no frames after the score file");
        end
        $display("Verification passed");
        $finish;
    end

endmodule

// ==== logic/digit_classifier.sv ====
`timescale 1ns/1ps

module digit_classifier (
    input logic clk,
    input logic reset,
    input logic rx,
    output logic tx,
    output logic [4:0] state_led,
    output num_pkg::row_t answer,
    output logic number_valid
);
    byte_link_if link ();
    ram_if ram ();
    acc_if acc ();

    uart_rx u_uart_rx (
        .clk(clk),
        .reset(reset),
        .rx(rx),
        .link(link)
    );

    uart_tx u_uart_tx (
        .clk(clk),
        .reset(reset),
        .tx(tx),
        .link(link)
    );

    scratch_ram u_scratch_ram (
        .clk(clk),
        .mem(ram)
    );

    dense_accumulator u_dense_accumulator (
        .clk(clk),
        .reset(reset),
        .acc(acc)
    );

    answer_select u_answer_select (
        .clk(clk),
        .reset(reset),
        .acc(acc),
        .answer(answer)
    );

    infer_sequencer u_infer_sequencer (
        .clk(clk),
        .reset(reset),
        .link(link),
        .mem(ram),
        .acc(acc),
        .state_led(state_led),
        .number_valid(number_valid)
    );

endmodule

// ==== logic/infer_sequencer.sv ====
`timescale 1ns/1ps
`include "classifier_consts.svh"

module infer_sequencer (
    input logic clk,
    input logic reset,
    byte_link_if.ctrl link,
    ram_if.master mem,
    acc_if.ctrl acc,
    output logic [4:0] state_led,
    output logic number_valid
);
    import num_pkg::*;
    import link_pkg::*;

    seq_phase_t phase;
    file_id_t file_id;
    ram_addr_t cnt;
    logic half;
    logic [1:0] byte_sel;
    logic tx_ready;
    logic last_byte;
    logic bias_area;
    ram_addr_t file_len;

    // tx_en still high means the uart has not latched yet
    assign tx_ready = !link.tx_busy && !link.tx_en;

    always_comb begin
        case (file_id)
            FILE_INPUT: file_len = ram_addr_t'(`CLS_N_IN);
            FILE_WEIGHT: file_len = ram_addr_t'(`CLS_N_IN * `CLS_N_OUT);
            default: file_len = ram_addr_t'(`CLS_N_OUT);
        endcase
    end

    assign last_byte = (cnt == file_len - 1'b1);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            phase <= IDLE;
            file_id <= FILE_INPUT;
            cnt <= '0;
            half <= 1'b0;
            byte_sel <= '0;
            link.tx_en <= 1'b0;
            link.tx_data <= '0;
        end else begin
            link.tx_en <= 1'b0;
            case (phase)
                IDLE: begin
                    file_id <= FILE_INPUT;
                    cnt <= '0;
                    phase <= SEND_HEAD;
                end
                SEND_HEAD: if (tx_ready) begin
                    link.tx_data <= (file_id == FILE_SCORE) ? byte_t'(`CLS_CMD_WRITE)
                                                            : byte_t'(`CLS_CMD_READ);
                    link.tx_en <= 1'b1;
                    cnt <= '0;
                    phase <= SEND_INDEX;
                end
                SEND_INDEX: if (tx_ready) begin
                    // high byte first
                    link.tx_data <= cnt[0] ? file_id[7:0] : file_id[15:8];
                    link.tx_en <= 1'b1;
                    cnt <= cnt + 1'b1;
                    if (cnt[0]) begin
                        cnt <= '0;
                        phase <= (file_id == FILE_SCORE) ? WRITE_SCORES : GET_BYTES;
                    end
                end
                GET_BYTES: if (link.rx_rdy) begin
                    cnt <= cnt + 1'b1;
                    if (last_byte) begin
                        cnt <= '0;
                        if (file_id == FILE_BIAS) begin
                            phase <= CLEAR;
                        end else begin
                            file_id <= file_id + 1'b1;
                            phase <= SEND_HEAD;
                        end
                    end
                end
                CLEAR: begin
                    cnt <= '0;
                    half <= 1'b0;
                    phase <= MAC;
                end
                MAC: begin
                    // even cycle reads the weight, odd cycle accumulates
                    half <= ~half;
                    if (half) begin
                        cnt <= cnt + 1'b1;
                        if (cnt == ram_addr_t'(`CLS_N_IN * `CLS_N_OUT - 1)) begin
                            cnt <= '0;
                            phase <= BIAS;
                        end
                    end
                end
                BIAS: begin
                    half <= ~half;
                    if (half) begin
                        cnt <= cnt + 1'b1;
                        if (cnt == ram_addr_t'(`CLS_N_OUT - 1)) begin
                            cnt <= '0;
                            file_id <= FILE_SCORE;
                            phase <= SEND_HEAD;
                        end
                    end
                end
                WRITE_SCORES: begin
                    byte_sel <= '0;
                    phase <= SEND_BYTES;
                end
                SEND_BYTES: if (tx_ready) begin
                    link.tx_data <= acc.score_byte;
                    link.tx_en <= 1'b1;
                    byte_sel <= byte_sel + 1'b1;
                    if (byte_sel == 2'(`CLS_SCORE_BYTES - 1)) begin
                        cnt <= cnt + 1'b1;
                        phase <= (cnt == ram_addr_t'(`CLS_N_OUT - 1)) ? FIN : WRITE_SCORES;
                    end
                end
                FIN: phase <= FIN;
                default: phase <= IDLE;
            endcase
        end
    end

    // memory port
    assign bias_area = (phase == BIAS) || (phase == GET_BYTES && file_id == FILE_BIAS);
    assign mem.addr = bias_area ? ram_addr_t'(`CLS_BIAS_BASE + cnt) : cnt;
    assign mem.we = (phase == GET_BYTES) && link.rx_rdy && (file_id != FILE_INPUT);
    assign mem.wdata = link.rx_data;

    // accumulator control
    assign acc.clear = (phase == CLEAR);
    assign acc.x_we = (phase == GET_BYTES) && link.rx_rdy && (file_id == FILE_INPUT);
    assign acc.col = col_t'(cnt[3:0]);
    assign acc.row = (phase == MAC) ? row_t'(cnt[7:4]) : row_t'(cnt[3:0]);
    assign acc.operand = operand_t'((phase == GET_BYTES) ? link.rx_data : mem.rdata);
    assign acc.mac_en = (phase == MAC) && half;
    assign acc.bias_en = (phase == BIAS) && half;
    assign acc.byte_sel = byte_sel;
    assign acc.score_strobe = (phase == WRITE_SCORES);

    assign state_led = phase;
    assign number_valid = (phase == FIN);

endmodule

// ==== logic/answer_select.sv ====
`timescale 1ns/1ps

module answer_select (
    input logic clk,
    input logic reset,
    acc_if.watch acc,
    output num_pkg::row_t answer
);
    import num_pkg::*;

    score_t best;
    row_t best_row;

    // strictly greater, so ties keep the lower row
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            best <= '0;
            best_row <= '0;
        end else if (acc.score_strobe) begin
            if (acc.row == '0 || acc.score > best) begin
                best <= acc.score;
                best_row <= acc.row;
            end
        end
    end

    assign answer = best_row;

endmodule

// ==== logic/dense_accumulator.sv ====
`timescale 1ns/1ps
`include "classifier_consts.svh"

module dense_accumulator (
    input logic clk,
    input logic reset,
    acc_if.unit acc
);
    import num_pkg::*;

    operand_t x_reg [`CLS_N_IN];
    score_t acc_reg [`CLS_N_OUT];
    logic signed [15:0] product;

    always_ff @(posedge clk) begin
        if (acc.x_we) begin
            x_reg[acc.col] <= acc.operand;
        end
    end

    assign product = acc.operand * x_reg[acc.col];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `CLS_N_OUT; i++) begin
                acc_reg[i] <= '0;
            end
        end else if (acc.clear) begin
            for (int i = 0; i < `CLS_N_OUT; i++) begin
                acc_reg[i] <= '0;
            end
        end else if (acc.mac_en) begin
            acc_reg[acc.row] <= acc_reg[acc.row] + score_t'(product);
        end else if (acc.bias_en) begin
            acc_reg[acc.row] <= acc_reg[acc.row] + score_t'(acc.operand);
        end
    end

    assign acc.score = acc_reg[acc.row];

    // byte 0 is the most significant
    always_comb begin
        case (acc.byte_sel)
            2'd0: acc.score_byte = acc.score[23:16];
            2'd1: acc.score_byte = acc.score[15:8];
            default: acc.score_byte = acc.score[7:0];
        endcase
    end

endmodule

// ==== logic/scratch_ram.sv ====
`timescale 1ns/1ps
`include "classifier_consts.svh"

module scratch_ram (
    input logic clk,
    ram_if.mem mem
);
    import link_pkg::*;

    // weights row-major from 0, biases from the bias base
    byte_t ram [`CLS_RAM_DEPTH];

    always_ff @(posedge clk) begin
        if (mem.we) begin
            ram[mem.addr] <= mem.wdata;
        end
        mem.rdata <= ram[mem.addr];
    end

endmodule

// ==== logic/uart_tx.sv ====
`timescale 1ns/1ps
`include "classifier_consts.svh"

module uart_tx (
    input logic clk,
    input logic reset,
    output logic tx,
    byte_link_if.phy link
);
    import link_pkg::*;

    localparam int CNT_W = $clog2(`CLS_CLKS_PER_BIT);

    logic busy;
    logic [CNT_W-1:0] clk_cnt;
    logic [3:0] bit_idx;
    byte_t data_sr;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tx <= 1'b1;
            busy <= 1'b0;
            clk_cnt <= '0;
            bit_idx <= '0;
        end else if (!busy) begin
            if (link.tx_en) begin
                // start bit goes out right away
                tx <= 1'b0;
                busy <= 1'b1;
                clk_cnt <= CNT_W'(`CLS_CLKS_PER_BIT - 1);
                bit_idx <= '0;
            end
        end else if (clk_cnt != '0) begin
            clk_cnt <= clk_cnt - 1'b1;
        end else begin
            clk_cnt <= CNT_W'(`CLS_CLKS_PER_BIT - 1);
            if (bit_idx == 4'd9) begin
                busy <= 1'b0;
            end else begin
                bit_idx <= bit_idx + 1'b1;
                tx <= (bit_idx < 4'd8) ? data_sr[0] : 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && link.tx_en) begin
            data_sr <= link.tx_data;
        end else if (busy && clk_cnt == '0 && bit_idx < 4'd8) begin
            data_sr <= data_sr >> 1;
        end
    end

    assign link.tx_busy = busy;

endmodule

// ==== logic/uart_rx.sv ====
`timescale 1ns/1ps
`include "classifier_consts.svh"

module uart_rx (
    input logic clk,
    input logic reset,
    input logic rx,
    byte_link_if.phy link
);
    import link_pkg::*;

    localparam int CNT_W = $clog2(`CLS_CLKS_PER_BIT);

    logic [2:0] rx_sync;
    logic active;
    logic [CNT_W-1:0] clk_cnt;
    logic [3:0] bit_idx;
    byte_t shift_reg;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rx_sync <= '1;
            active <= 1'b0;
            clk_cnt <= '0;
            bit_idx <= '0;
            link.rx_rdy <= 1'b0;
        end else begin
            rx_sync <= {rx_sync[1:0], rx};
            link.rx_rdy <= 1'b0;
            if (!active) begin
                // falling edge opens a frame, first sample at mid start bit
                if (rx_sync[2] && !rx_sync[1]) begin
                    active <= 1'b1;
                    bit_idx <= '0;
                    clk_cnt <= CNT_W'(`CLS_CLKS_PER_BIT / 2 - 1);
                end
            end else if (clk_cnt != '0) begin
                clk_cnt <= clk_cnt - 1'b1;
            end else begin
                clk_cnt <= CNT_W'(`CLS_CLKS_PER_BIT - 1);
                bit_idx <= bit_idx + 1'b1;
                if (bit_idx == 4'd0 && rx_sync[1]) begin
                    // glitch, not a start bit
                    active <= 1'b0;
                end else if (bit_idx == 4'd9) begin
                    active <= 1'b0;
                    link.rx_rdy <= rx_sync[1];
                end
            end
        end
    end

    // data bits arrive lsb first
    always_ff @(posedge clk) begin
        if (active && clk_cnt == '0 && bit_idx >= 4'd1 && bit_idx <= 4'd8) begin
            shift_reg <= {rx_sync[1], shift_reg[7:1]};
        end
    end

    assign link.rx_data = shift_reg;

endmodule

// ==== logic/design_ifs.sv ====
`timescale 1ns/1ps

// byte strobes between the sequencer and both UARTs
interface byte_link_if;
    import link_pkg::*;

    byte_t tx_data;
    logic tx_en;
    logic tx_busy;
    byte_t rx_data;
    logic rx_rdy;

    modport ctrl (output tx_data, output tx_en, input tx_busy, input rx_data, input rx_rdy);
    modport phy (input tx_data, input tx_en, output tx_busy, output rx_data, output rx_rdy);
endinterface

// scratch memory port, read data one cycle after addr
interface ram_if;
    import link_pkg::*;

    logic we;
    ram_addr_t addr;
    byte_t wdata;
    byte_t rdata;

    modport master (output we, output addr, output wdata, input rdata);
    modport mem (input we, input addr, input wdata, output rdata);
endinterface

interface acc_if;
    import num_pkg::*;

    logic clear;
    logic x_we;
    col_t col;
    row_t row;
    operand_t operand;
    logic mac_en;
    logic bias_en;
    logic [1:0] byte_sel;
    logic [7:0] score_byte;
    logic score_strobe;
    score_t score;

    modport ctrl (
        output clear, output x_we, output col, output row, output operand,
        output mac_en, output bias_en, output byte_sel, output score_strobe,
        input score_byte
    );
    modport unit (
        input clear, input x_we, input col, input row, input operand,
        input mac_en, input bias_en, input byte_sel,
        output score_byte, output score
    );
    modport watch (input score_strobe, input row, input score);
endinterface

// ==== logic/link_pkg.sv ====
package link_pkg;

    typedef logic [7:0] byte_t;
    typedef logic [15:0] file_id_t;
    typedef logic [7:0] ram_addr_t;

    // host file numbers
    localparam file_id_t FILE_INPUT = 16'd0;
    localparam file_id_t FILE_WEIGHT = 16'd1;
    localparam file_id_t FILE_BIAS = 16'd2;
    localparam file_id_t FILE_SCORE = 16'd3;

    typedef enum logic [4:0] {
        IDLE,
        SEND_HEAD,
        SEND_INDEX,
        GET_BYTES,
        SEND_BYTES,
        CLEAR,
        MAC,
        BIAS,
        WRITE_SCORES,
        FIN
    } seq_phase_t;

endpackage

// ==== logic/num_pkg.sv ====
package num_pkg;

    // input, weight or bias byte
    typedef logic signed [7:0] operand_t;

    // accumulator wide enough for 16 products plus bias
    typedef logic signed [23:0] score_t;

    typedef logic [3:0] col_t;
    typedef logic [3:0] row_t;

endpackage

// ==== logic/classifier_consts.svh ====
`ifndef CLASSIFIER_CONSTS_SVH
`define CLASSIFIER_CONSTS_SVH

// layer shape
`define CLS_N_IN 16
`define CLS_N_OUT 10
`define CLS_SCORE_BYTES 3

// serial link
`define CLS_CLKS_PER_BIT 8
`define CLS_CMD_READ 82
`define CLS_CMD_WRITE 87

// scratch memory map, biases after the weights
`define CLS_RAM_DEPTH 170
`define CLS_BIAS_BASE 160

`endif
